//--- sqrt_unit.f
+incdir+include
hdl/sqrt_data_pkg.sv
hdl/sqrt_ctrl_pkg.sv
hdl/sqrt_operand_capture.sv
hdl/sqrt_square_mul.sv
hdl/sqrt_bit_fsm.sv
hdl/sqrt_top.sv
bench/sqrt_tb.sv

//--- Makefile
# Verilator build and run for the square-root unit.
# Override any variable on the command line, e.g. make run SEED=3

VERILATOR ?= verilator
TOP       ?= sqrt_tb
SEED      ?= 10
FILELIST  ?= sqrt_unit.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/10ps

.PHONY: all compile run clean

all: run

# builds the testbench executable.
compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Gstart_seed=$(SEED) \
		--Mdir $(BUILD_DIR) -f $(FILELIST)

# exit status is nonzero when the testbench stops with $fatal.
run: compile
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

//--- bench/sqrt_tb.sv
`timescale 1ns/10ps
`default_nettype none

module sqrt_tb #(
    parameter int start_seed = 10
);
    import sqrt_data_pkg::*;

    localparam int num_random  = 200;
    localparam int num_squares = 4;
    localparam int num_ops     = 210;  // random, squares and edge operands.
    localparam int op_cycles   = 110;  // worst case per operand with margin.
    localparam int max_cycles  = num_ops * op_cycles;
    localparam int hold_cycles = 20;

    logic     clk;
    logic     rst_n;
    operand_t operand;
    root_t    root;
    logic     done;

    integer   seed;
    int       cycle_count;
    operand_t last_operand;
    root_t    last_root;

    sqrt_top u_dut (
        .clk     (clk),
        .rst_n   (rst_n),
        .operand (operand),
        .root    (root),
        .done    (done)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Errors found");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_root(input root_t got, input root_t exp, input string name);
        if (got !== exp) begin
            report_failure($sformatf("mismatch at %0t: %s got %h, expected %h",
                                     $time, name, got, exp));
        end
    endtask

    task automatic check_done(input logic got, input logic exp, input string name);
        if (got !== exp) begin
            report_failure($sformatf("mismatch at %0t: %s got %b, expected %b",
                                     $time, name, got, exp));
        end
    endtask

    // digit-by-digit square root on the remainder.
    function automatic root_t model_sqrt(input operand_t value);
        logic [64:0] rest;
        logic [64:0] res;
        logic [64:0] one;
        rest = {1'b0, value};
        res  = '0;
        one  = 65'd1 << 62;
        while (one > rest) begin
            one = one >> 2;
        end
        while (one != 0) begin
            if (rest >= res + one) begin
                rest = rest - (res + one);
                res  = (res >> 1) + one;
            end else begin
                res = res >> 1;
            end
            one = one >> 2;
        end
        return root_t'(res);
    endfunction

    // one computation, from the operand change to done rising again.
    task automatic run_operand(input operand_t value);
        root_t expected;
        expected = model_sqrt(value);
        if (value == last_operand) begin
            report_failure("operand equals the previous one, so no computation would start");
        end
        @(posedge clk);
        operand <= value;
        repeat (2) @(posedge clk);
        @(negedge clk);
        check_done(done, 1'b1, "done");  // start only just raised.
        @(posedge clk);
        @(negedge clk);
        check_done(done, 1'b0, "done");
        while (!done) begin
            @(negedge clk);
        end
        check_root(root, expected, "root");
        last_operand = value;
        last_root    = expected;
    endtask

    initial begin
        operand_t value;
        root_t    base;
        seed         = start_seed;
        rst_n        = 1'b0;
        operand      = '0;
        last_operand = '0;
        last_root    = '0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_done(done, 1'b1, "done");
        check_root(root, '0, "root");

        for (int i = 0; i < num_random; i++) begin
            value = {$random(seed), $random(seed)};
            while (value == last_operand) begin
                value = {$random(seed), $random(seed)};
            end
            run_operand(value);
        end

        // exact squares take the early exit.
        for (int i = 0; i < num_squares; i++) begin
            base  = $random(seed);
            value = operand_t'(base) * operand_t'(base);
            while (base < 2 || value == last_operand) begin
                base  = $random(seed);
                value = operand_t'(base) * operand_t'(base);
            end
            run_operand(value);
            check_root(root, base, "root");
        end

        run_operand(64'd1);
        check_root(root, 32'd1, "root");
        run_operand(64'd2);
        check_root(root, 32'd1, "root");
        run_operand(64'd3);
        check_root(root, 32'd1, "root");
        run_operand(64'd4);
        check_root(root, 32'd2, "root");
        run_operand('1);
        check_root(root, '1, "root");
        run_operand('0);  // zero after a nonzero value.
        check_root(root, '0, "root");

        // unchanged operand must not restart the unit.
        repeat (hold_cycles) begin
            @(negedge clk);
            check_done(done, 1'b1, "done");
            check_root(root, last_root, "root");
        end

        $display("No errors");
        $finish;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < max_cycles) begin
            @(posedge clk);
            cycle_count++;
        end
        report_failure($sformatf("timeout: run still busy after %0d cycles", max_cycles));
    end

endmodule

`default_nettype wire

//--- hdl/sqrt_top.sv
`timescale 1ns/10ps
`default_nettype none

module sqrt_top (
    input  logic                    clk,
    input  logic                    rst_n,
    input  sqrt_data_pkg::operand_t operand,
    output sqrt_data_pkg::root_t    root,
    output logic                    done
);
    import sqrt_data_pkg::*;
    import sqrt_ctrl_pkg::*;

    logic      start;
    sqrt_job_t job;
    root_t     trial;
    square_t   square;

    sqrt_operand_capture u_capture (
        .clk     (clk),
        .rst_n   (rst_n),
        .operand (operand),
        .start   (start),
        .job     (job)
    );

    sqrt_bit_fsm u_fsm (
        .clk    (clk),
        .rst_n  (rst_n),
        .start  (start),
        .job    (job),
        .square (square),
        .trial  (trial),
        .root   (root),
        .done   (done)
    );

    sqrt_square_mul u_mul (
        .clk    (clk),
        .rst_n  (rst_n),
        .trial  (trial),
        .square (square)
    );

endmodule

`default_nettype wire

//--- hdl/sqrt_bit_fsm.sv
`timescale 1ns/10ps
`default_nettype none

`include "sqrt_cfg.svh"

module sqrt_bit_fsm (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     start,
    input  sqrt_ctrl_pkg::sqrt_job_t job,
    input  sqrt_data_pkg::square_t   square,
    output sqrt_data_pkg::root_t     trial,
    output sqrt_data_pkg::root_t     root,
    output logic                     done
);
    import sqrt_data_pkg::*;
    import sqrt_ctrl_pkg::*;

    localparam int cnt_w = $clog2(`SQRT_MUL_LATENCY + 1);

    sqrt_state_e      state;
    bit_idx_t         idx;
    operand_t         target;
    logic [cnt_w-1:0] wait_cnt;

    // operand under test, kept for the whole search.
    always_ff @(posedge clk) begin
        if (start) begin
            target <= job.operand;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= st_idle;
            idx      <= '0;
            wait_cnt <= '0;
            trial    <= '0;
            root     <= '0;
            done     <= 1'b1;
        end else begin
            case (state)
                st_idle: begin
                    if (start) begin
                        trial <= '0;
                        idx   <= job.top_idx;
                        done  <= 1'b0;
                        // zero operand skips the search.
                        state <= job.nonzero ? st_set_bit : st_finish;
                    end
                end
                st_set_bit: begin
                    trial[idx] <= 1'b1;
                    wait_cnt   <= cnt_w'(`SQRT_MUL_LATENCY - 1);
                    state      <= st_wait_mul;
                end
                st_wait_mul: begin
                    if (wait_cnt == '0) begin
                        state <= st_check_bit;  // square valid next cycle.
                    end else begin
                        wait_cnt <= wait_cnt - 1'b1;
                    end
                end
                st_check_bit: begin
                    if (square == target) begin
                        state <= st_finish;  // exact root, lower bits stay 0.
                    end else begin
                        if (square > target) begin
                            trial[idx] <= 1'b0;  // overshoot, drop bit.
                        end
                        if (idx == '0) begin
                            state <= st_finish;
                        end else begin
                            idx   <= idx - 1'b1;
                            state <= st_set_bit;
                        end
                    end
                end
                st_finish: begin
                    root  <= trial;
                    done  <= 1'b1;
                    state <= st_idle;
                end
                default: begin
                    done  <= 1'b1;
                    state <= st_idle;
                end
            endcase
        end
    end

    a_done_idle: assert property (
        @(posedge clk) disable iff (!rst_n)
        done == (state == st_idle)
    ) else $error("done out of step with idle state");

    // operand held until done rises keeps capture quiet while busy.
    a_start_idle: assert property (
        @(posedge clk) disable iff (!rst_n)
        start |-> (state == st_idle)
    ) else $error("start while busy");

endmodule

`default_nettype wire

//--- hdl/sqrt_square_mul.sv
`timescale 1ns/10ps
`default_nettype none

`include "sqrt_cfg.svh"

module sqrt_square_mul (
    input  logic                    clk,
    input  logic                    rst_n,
    input  sqrt_data_pkg::root_t    trial,
    output sqrt_data_pkg::square_t  square
);
    import sqrt_data_pkg::*;

    square_t pipe [`SQRT_MUL_LATENCY];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `SQRT_MUL_LATENCY; i++) begin
                pipe[i] <= '0;
            end
        end else begin
            pipe[0] <= square_t'(trial) * square_t'(trial);  // full 64-bit product.
            for (int i = 1; i < `SQRT_MUL_LATENCY; i++) begin
                pipe[i] <= pipe[i-1];
            end
        end
    end

    assign square = pipe[`SQRT_MUL_LATENCY-1];

endmodule

`default_nettype wire

//--- hdl/sqrt_operand_capture.sv
`timescale 1ns/10ps
`default_nettype none

`include "sqrt_cfg.svh"

module sqrt_operand_capture (
    input  logic                     clk,
    input  logic                     rst_n,
    input  sqrt_data_pkg::operand_t  operand,
    output logic                     start,
    output sqrt_ctrl_pkg::sqrt_job_t job
);
    import sqrt_data_pkg::*;

    operand_t op_r0;
    operand_t op_r1;
    bit_idx_t lead_idx;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            op_r0 <= '0;
            op_r1 <= '0;
            start <= 1'b0;
        end else begin
            op_r0 <= operand;
            op_r1 <= op_r0;
            start <= (op_r0 != op_r1);  // new value seen in first stage.
        end
    end

    // highest nonzero bit pair gives the top root bit.
    always_comb begin
        lead_idx = '0;
        for (int k = 0; k < `SQRT_ROOT_W; k++) begin
            if (op_r0[2*k +: 2] != 2'b00) begin
                lead_idx = bit_idx_t'(k);  // later pairs win.
            end
        end
    end

    assign job.operand = op_r0;
    assign job.top_idx = lead_idx;
    assign job.nonzero = |op_r0;

    // holds while the operand changes no faster than every other cycle.
    a_start_pulse: assert property (
        @(posedge clk) disable iff (!rst_n)
        start |=> !start
    ) else $error("start high for two cycles");

endmodule

`default_nettype wire

//--- hdl/sqrt_ctrl_pkg.sv
`default_nettype none

package sqrt_ctrl_pkg;

    typedef enum logic [2:0] {
        st_idle,
        st_set_bit,
        st_wait_mul,
        st_check_bit,
        st_finish
    } sqrt_state_e;

    // one computation request, 70 bits.
    typedef struct packed {
        sqrt_data_pkg::operand_t operand;
        sqrt_data_pkg::bit_idx_t top_idx;   // highest root bit worth trying.
        logic                    nonzero;   // low for a zero operand.
    } sqrt_job_t;

endpackage

`default_nettype wire

//--- hdl/sqrt_data_pkg.sv
`default_nettype none

`include "sqrt_cfg.svh"

package sqrt_data_pkg;

    // unsigned radicand.
    typedef logic [`SQRT_OPERAND_W-1:0] operand_t;

    // final or trial root.
    typedef logic [`SQRT_ROOT_W-1:0] root_t;

    // square of a root, fits the operand width.
    typedef logic [`SQRT_OPERAND_W-1:0] square_t;

    // root bit position.
    typedef logic [`SQRT_IDX_W-1:0] bit_idx_t;

endpackage

`default_nettype wire

//--- include/sqrt_cfg.svh
`ifndef SQRT_CFG_SVH
`define SQRT_CFG_SVH

// radicand width in bits.
`define SQRT_OPERAND_W 64

`define SQRT_ROOT_W (`SQRT_OPERAND_W / 2)

// enough to index every root bit.
`define SQRT_IDX_W 5

`define SQRT_MUL_LATENCY 1

`endif
